// ==== common/exu_macros.svh ====
// execute stage widths and counts
// shared by the RTL and the testbench
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// data path width
`define EXU_XLEN 32

// register file address width
`define EXU_REG_ADDR_W 5

// one multiply/divide step per cycle, one bit per step
`define EXU_MULDIV_STEPS 32

// instruction size, used for the link value
`define EXU_PC_STEP 4

`endif

// ==== common/exu_pkg.sv ====
// execute stage types
// opcode, unit class and multiply/divide FSM encodings
package exu_pkg;

    // decoded operation, one per supported instruction
    typedef enum logic [4:0] {
        OP_NONE  = 5'd0,
        OP_ADD   = 5'd1,
        OP_SUB   = 5'd2,
        OP_SLL   = 5'd3,
        OP_SLT   = 5'd4,
        OP_SLTU  = 5'd5,
        OP_XOR   = 5'd6,
        OP_SRL   = 5'd7,
        OP_SRA   = 5'd8,
        OP_OR    = 5'd9,
        OP_AND   = 5'd10,
        OP_LUI   = 5'd11,
        OP_AUIPC = 5'd12,
        OP_JAL   = 5'd13,
        OP_JALR  = 5'd14,
        OP_BEQ   = 5'd15,
        OP_BNE   = 5'd16,
        OP_BLT   = 5'd17,
        OP_BGE   = 5'd18,
        OP_BLTU  = 5'd19,
        OP_BGEU  = 5'd20,
        OP_MUL   = 5'd21,
        OP_MULHU = 5'd22,
        OP_DIVU  = 5'd23,
        OP_REMU  = 5'd24
    } exu_op_e;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ALU,
        UNIT_BRU,
        UNIT_MULDIV
    } exu_unit_e;

    typedef enum logic [1:0] {
        MD_IDLE,
        MD_MUL,
        MD_DIV,
        MD_DONE
    } muldiv_state_e;

endpackage

// ==== common/muldiv_if.sv ====
// multiply/divide request and result bus
// dispatch issues, the iterative unit computes, commit writes back
`include "exu_macros.svh"

interface muldiv_if;
    import exu_pkg::*;

    // request side
    logic                       start;
    logic                       kill;
    exu_op_e                    op;
    logic [`EXU_XLEN-1:0]       op_a;
    logic [`EXU_XLEN-1:0]       op_b;
    logic [`EXU_REG_ADDR_W-1:0] rd;

    // result side
    logic                       busy;
    logic                       done;
    logic [`EXU_XLEN-1:0]       result_data;
    logic [`EXU_REG_ADDR_W-1:0] done_rd;

    modport issue (output start, kill, op, op_a, op_b, rd, input busy);
    modport unit (input start, kill, op, op_a, op_b, rd,
                  output busy, done, result_data, done_rd);
    modport result (input busy, done, result_data, done_rd);

endinterface

// ==== design/exu_dispatch.sv ====
// instruction dispatch
// sorts the opcode into a unit class, picks the second ALU operand
// and issues multiply/divide requests to the iterative unit
`include "exu_macros.svh"

module exu_dispatch (
    input  logic                       valid_i,
    input  exu_pkg::exu_op_e           op_i,
    input  logic [`EXU_XLEN-1:0]       rs1_i,
    input  logic [`EXU_XLEN-1:0]       rs2_i,
    input  logic [`EXU_XLEN-1:0]       imm_i,
    input  logic                       use_imm_i,
    input  logic [`EXU_REG_ADDR_W-1:0] rd_i,
    input  logic                       int_assert_i,
    output exu_pkg::exu_unit_e         unit_o,
    output logic [`EXU_XLEN-1:0]       op_b_o,
    muldiv_if.issue                    md
);
    import exu_pkg::*;

    exu_unit_e unit_dec;

    always_comb begin
        case (op_i)
            OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR,
            OP_SRL, OP_SRA, OP_OR, OP_AND, OP_LUI, OP_AUIPC: unit_dec = UNIT_ALU;
            OP_JAL, OP_JALR, OP_BEQ, OP_BNE,
            OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:                unit_dec = UNIT_BRU;
            OP_MUL, OP_MULHU, OP_DIVU, OP_REMU:              unit_dec = UNIT_MULDIV;
            default:                                         unit_dec = UNIT_NONE;
        endcase
    end

    // valid_i is ignored while a multiply/divide is in flight
    assign unit_o = (valid_i && !md.busy) ? unit_dec : UNIT_NONE;

    assign op_b_o = use_imm_i ? imm_i : rs2_i;

    // an interrupt cancels the running op and blocks a new one
    assign md.start = (unit_o == UNIT_MULDIV) && !int_assert_i;
    assign md.kill  = int_assert_i;

    // multiply/divide always takes both register operands
    assign md.op   = op_i;
    assign md.op_a = rs1_i;
    assign md.op_b = rs2_i;
    assign md.rd   = rd_i;

endmodule

// ==== design/exu_alu.sv ====
// single-cycle integer ALU
// register/register and register/immediate ops, LUI and AUIPC
`include "exu_macros.svh"

module exu_alu (
    input  exu_pkg::exu_op_e     op_i,
    input  logic [`EXU_XLEN-1:0] pc_i,
    input  logic [`EXU_XLEN-1:0] op_a_i,
    input  logic [`EXU_XLEN-1:0] op_b_i,
    input  logic [`EXU_XLEN-1:0] imm_i,
    output logic [`EXU_XLEN-1:0] result_o
);
    import exu_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // only the low five bits count for a shift
    assign shamt       = op_b_i[4:0];
    assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
    assign lt_unsigned = op_a_i < op_b_i;

    always_comb begin
        case (op_i)
            OP_ADD:   result_o = op_a_i + op_b_i;
            OP_SUB:   result_o = op_a_i - op_b_i;
            OP_SLL:   result_o = op_a_i << shamt;
            OP_SLT:   result_o = {{(`EXU_XLEN-1){1'b0}}, lt_signed};
            OP_SLTU:  result_o = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned};
            OP_XOR:   result_o = op_a_i ^ op_b_i;
            OP_SRL:   result_o = op_a_i >> shamt;
            OP_SRA:   result_o = $unsigned($signed(op_a_i) >>> shamt);
            OP_OR:    result_o = op_a_i | op_b_i;
            OP_AND:   result_o = op_a_i & op_b_i;
            // decoder already placed the upper immediate
            OP_LUI:   result_o = imm_i;
            OP_AUIPC: result_o = pc_i + imm_i;
            default:  result_o = '0;
        endcase
    end

endmodule

// ==== design/exu_bru.sv ====
// branch unit
// evaluates branch conditions, forms the jump target
// and the link value for JAL/JALR
`include "exu_macros.svh"

module exu_bru (
    input  exu_pkg::exu_op_e     op_i,
    input  logic [`EXU_XLEN-1:0] pc_i,
    input  logic [`EXU_XLEN-1:0] rs1_i,
    input  logic [`EXU_XLEN-1:0] rs2_i,
    input  logic [`EXU_XLEN-1:0] imm_i,
    output logic                 taken_o,
    output logic                 jump_o,
    output logic [`EXU_XLEN-1:0] target_o,
    output logic [`EXU_XLEN-1:0] link_o
);
    import exu_pkg::*;

    logic [`EXU_XLEN-1:0] jalr_sum;

    always_comb begin
        case (op_i)
            OP_JAL, OP_JALR: taken_o = 1'b1;
            OP_BEQ:          taken_o = rs1_i == rs2_i;
            OP_BNE:          taken_o = rs1_i != rs2_i;
            OP_BLT:          taken_o = $signed(rs1_i) < $signed(rs2_i);
            OP_BGE:          taken_o = $signed(rs1_i) >= $signed(rs2_i);
            OP_BLTU:         taken_o = rs1_i < rs2_i;
            OP_BGEU:         taken_o = rs1_i >= rs2_i;
            default:         taken_o = 1'b0;
        endcase
    end

    // jumps write the link register, branches do not
    assign jump_o = (op_i == OP_JAL) || (op_i == OP_JALR);

    // JALR target is register relative with bit 0 cleared
    assign jalr_sum = rs1_i + imm_i;
    assign target_o = (op_i == OP_JALR) ? {jalr_sum[`EXU_XLEN-1:1], 1'b0} : pc_i + imm_i;

    assign link_o = pc_i + `EXU_XLEN'(`EXU_PC_STEP);

endmodule

// ==== design/exu_commit.sv ====
// write-back and redirect merge
// picks the register write from the multiply/divide result, the ALU
// or the link value, drives the fetch redirect and the hold request,
// and applies the interrupt override
`include "exu_macros.svh"

module exu_commit (
    input  exu_pkg::exu_unit_e         unit_i,
    input  logic [`EXU_REG_ADDR_W-1:0] rd_i,
    input  logic [`EXU_XLEN-1:0]       alu_result_i,
    input  logic                       taken_i,
    input  logic                       jump_i,
    input  logic [`EXU_XLEN-1:0]       target_i,
    input  logic [`EXU_XLEN-1:0]       link_i,
    input  logic                       int_assert_i,
    input  logic [`EXU_XLEN-1:0]       int_addr_i,
    muldiv_if.result                   md,
    output logic                       reg_we_o,
    output logic [`EXU_REG_ADDR_W-1:0] reg_waddr_o,
    output logic [`EXU_XLEN-1:0]       reg_wdata_o,
    output logic                       jump_flag_o,
    output logic [`EXU_XLEN-1:0]       jump_addr_o,
    output logic                       hold_o
);
    import exu_pkg::*;

    logic                       wb_req;
    logic [`EXU_REG_ADDR_W-1:0] waddr;

    // finished multiply/divide wins over a single-cycle result
    assign waddr  = md.done ? md.done_rd : rd_i;
    assign wb_req = md.done || (unit_i == UNIT_ALU) || (unit_i == UNIT_BRU && jump_i);

    // x0 is never written
    assign reg_we_o    = wb_req && (waddr != '0) && !int_assert_i;
    assign reg_waddr_o = waddr;
    assign reg_wdata_o = md.done              ? md.result_data :
                         (unit_i == UNIT_ALU) ? alu_result_i   :
                                                link_i;

    assign jump_flag_o = int_assert_i || (unit_i == UNIT_BRU && taken_i);
    assign jump_addr_o = int_assert_i ? int_addr_i : target_i;

    // held from the issue cycle until the unit reports done
    assign hold_o = (unit_i == UNIT_MULDIV && !int_assert_i) || md.busy;

endmodule

// ==== muldiv/exu_muldiv.sv ====
// iterative multiply/divide unit
// shift-add multiplier for MUL/MULHU and restoring divider for
// DIVU/REMU, one bit per cycle, one operation in flight
// the cycle after the last step latches the selected word,
// then done pulses for one cycle
`include "exu_macros.svh"

module exu_muldiv (
    input  logic clk,
    input  logic rst_n_i,
    muldiv_if.unit md
);
    import exu_pkg::*;

    localparam int CNT_W = $clog2(`EXU_MULDIV_STEPS + 1);
    localparam logic [CNT_W-1:0] LAST_CNT = CNT_W'(`EXU_MULDIV_STEPS);

    muldiv_state_e              state_q;
    logic [CNT_W-1:0]           cnt_q;
    exu_op_e                    op_q;
    logic [`EXU_REG_ADDR_W-1:0] rd_q;
    // hi/lo hold the product, or the remainder and quotient
    logic [`EXU_XLEN-1:0]       hi_q;
    logic [`EXU_XLEN-1:0]       lo_q;
    logic [`EXU_XLEN-1:0]       b_q;
    logic [`EXU_XLEN-1:0]       result_q;
    logic                       accept;
    logic                       running;
    logic                       last;
    logic                       low_word;
    logic [`EXU_XLEN:0]         mul_sum;
    logic [`EXU_XLEN:0]         div_shift;
    logic [`EXU_XLEN:0]         div_diff;

    assign running = (state_q == MD_MUL) || (state_q == MD_DIV);
    assign accept  = md.start && !running;
    assign last    = cnt_q == LAST_CNT;

    // multiply step adds the multiplicand when the low bit is set
    assign mul_sum = {1'b0, hi_q} + (lo_q[0] ? {1'b0, b_q} : '0);

    // divide step, a negative difference leaves the partial remainder
    assign div_shift = {hi_q, lo_q[`EXU_XLEN-1]};
    assign div_diff  = div_shift - {1'b0, b_q};

    assign low_word = (op_q == OP_MUL) || (op_q == OP_DIVU);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= MD_IDLE;
            cnt_q   <= '0;
        end else if (md.kill) begin
            state_q <= MD_IDLE;
        end else begin
            case (state_q)
                MD_IDLE, MD_DONE: begin
                    if (md.start) begin
                        state_q <= (md.op == OP_MUL || md.op == OP_MULHU) ? MD_MUL : MD_DIV;
                        cnt_q   <= '0;
                    end else begin
                        state_q <= MD_IDLE;
                    end
                end
                MD_MUL, MD_DIV: begin
                    if (last) begin
                        state_q <= MD_DONE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: state_q <= MD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            hi_q <= '0;
            lo_q <= md.op_a;
            b_q  <= md.op_b;
            op_q <= md.op;
            rd_q <= md.rd;
        end else if (running && !last) begin
            if (state_q == MD_MUL) begin
                {hi_q, lo_q} <= {mul_sum, lo_q[`EXU_XLEN-1:1]};
            end else if (!div_diff[`EXU_XLEN]) begin
                hi_q <= div_diff[`EXU_XLEN-1:0];
                lo_q <= {lo_q[`EXU_XLEN-2:0], 1'b1};
            end else begin
                hi_q <= div_shift[`EXU_XLEN-1:0];
                lo_q <= {lo_q[`EXU_XLEN-2:0], 1'b0};
            end
        end else if (running) begin
            result_q <= low_word ? lo_q : hi_q;
        end
    end

    assign md.busy        = running;
    assign md.done        = state_q == MD_DONE;
    assign md.result_data = result_q;
    assign md.done_rd     = rd_q;

endmodule

// ==== design/exu_top.sv ====
// execute stage of a small RV32IM core
// takes one decoded instruction per cycle and produces the
// register write-back, the fetch redirect and the hold request
// an asserted interrupt overrides all of them
`include "exu_macros.svh"

module exu_top (
    input  logic                       clk,
    input  logic                       rst_n_i,
    input  logic                       valid_i,
    input  exu_pkg::exu_op_e           op_i,
    input  logic [`EXU_XLEN-1:0]       pc_i,
    input  logic [`EXU_XLEN-1:0]       rs1_i,
    input  logic [`EXU_XLEN-1:0]       rs2_i,
    input  logic [`EXU_XLEN-1:0]       imm_i,
    input  logic                       use_imm_i,
    input  logic [`EXU_REG_ADDR_W-1:0] rd_i,
    input  logic                       int_assert_i,
    input  logic [`EXU_XLEN-1:0]       int_addr_i,
    output logic                       reg_we_o,
    output logic [`EXU_REG_ADDR_W-1:0] reg_waddr_o,
    output logic [`EXU_XLEN-1:0]       reg_wdata_o,
    output logic                       jump_flag_o,
    output logic [`EXU_XLEN-1:0]       jump_addr_o,
    output logic                       hold_o
);
    import exu_pkg::*;

    exu_unit_e            unit;
    logic [`EXU_XLEN-1:0] op_b;
    logic [`EXU_XLEN-1:0] alu_result;
    logic                 bru_taken;
    logic                 bru_jump;
    logic [`EXU_XLEN-1:0] bru_target;
    logic [`EXU_XLEN-1:0] bru_link;

    muldiv_if md_bus ();

    exu_dispatch u_dispatch (
        .valid_i     (valid_i),
        .op_i        (op_i),
        .rs1_i       (rs1_i),
        .rs2_i       (rs2_i),
        .imm_i       (imm_i),
        .use_imm_i   (use_imm_i),
        .rd_i        (rd_i),
        .int_assert_i(int_assert_i),
        .unit_o      (unit),
        .op_b_o      (op_b),
        .md          (md_bus)
    );

    exu_alu u_alu (
        .op_i    (op_i),
        .pc_i    (pc_i),
        .op_a_i  (rs1_i),
        .op_b_i  (op_b),
        .imm_i   (imm_i),
        .result_o(alu_result)
    );

    exu_bru u_bru (
        .op_i    (op_i),
        .pc_i    (pc_i),
        .rs1_i   (rs1_i),
        .rs2_i   (rs2_i),
        .imm_i   (imm_i),
        .taken_o (bru_taken),
        .jump_o  (bru_jump),
        .target_o(bru_target),
        .link_o  (bru_link)
    );

    exu_muldiv u_muldiv (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .md     (md_bus)
    );

    exu_commit u_commit (
        .unit_i      (unit),
        .rd_i        (rd_i),
        .alu_result_i(alu_result),
        .taken_i     (bru_taken),
        .jump_i      (bru_jump),
        .target_i    (bru_target),
        .link_i      (bru_link),
        .int_assert_i(int_assert_i),
        .int_addr_i  (int_addr_i),
        .md          (md_bus),
        .reg_we_o    (reg_we_o),
        .reg_waddr_o (reg_waddr_o),
        .reg_wdata_o (reg_wdata_o),
        .jump_flag_o (jump_flag_o),
        .jump_addr_o (jump_addr_o),
        .hold_o      (hold_o)
    );

endmodule

// ==== verif/exu_assert.sv ====
// execute stage protocol checks
// bound into the top level, watches the register write port,
// the hold request and the multiply/divide handshake
module exu_assert (
    input logic                   clk,
    input logic                   rst_n_i,
    input logic                   valid_i,
    input logic                   int_assert_i,
    input logic                   reg_we_i,
    input logic                   hold_i,
    input logic                   busy_i,
    input logic                   done_i,
    input exu_pkg::muldiv_state_e state_i
);
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    // interrupt blocks every register write
    no_write_on_irq: assert property (@(posedge clk) disable iff (!rst_n_i)
        int_assert_i |-> !reg_we_i)
        else $error("register write in a cycle with an interrupt");

    // hold only starts from an issue or a running unit
    hold_has_cause: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(hold_i) |-> (valid_i || busy_i))
        else $error("hold request rose without an issue or a busy unit");

    done_single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_i |=> !done_i)
        else $error("multiply/divide done held for more than one cycle");

    // result write never competes with a new instruction
    done_alone: assert property (@(posedge clk) disable iff (!rst_n_i)
        done_i |-> !valid_i)
        else $error("done pulse overlaps a new instruction");

    // an interrupt sends the unit back to idle
    kill_to_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
        int_assert_i |=> (state_i == MD_IDLE))
        else $error("multiply/divide unit not idle after an interrupt");

endmodule

bind exu_top exu_assert u_assert (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .int_assert_i(int_assert_i),
    .reg_we_i    (reg_we_o),
    .hold_i      (hold_o),
    .busy_i      (md_bus.busy),
    .done_i      (md_bus.done),
    .state_i     (u_muldiv.state_q)
);

// ==== verif/tb_exu.sv ====
// testbench for the execute stage
// replays the vectors of the data file through the DUT and checks
// write-back, redirect and hold against the expected columns
`include "exu_macros.svh"

module tb_exu;
    timeunit 1ns;
    timeprecision 1ps;
    import exu_pkg::*;

    localparam int HALF_PERIOD = 20;
    localparam int TIMEOUT     = 100;
    // cycles a cancelled op runs before the interrupt arrives
    localparam int IRQ_DELAY   = 4;

    logic                       clk = 1'b0;
    logic                       rst_n_i;
    logic                       valid_i;
    exu_op_e                    op_i;
    logic [`EXU_XLEN-1:0]       pc_i;
    logic [`EXU_XLEN-1:0]       rs1_i;
    logic [`EXU_XLEN-1:0]       rs2_i;
    logic [`EXU_XLEN-1:0]       imm_i;
    logic                       use_imm_i;
    logic [`EXU_REG_ADDR_W-1:0] rd_i;
    logic                       int_assert_i;
    logic [`EXU_XLEN-1:0]       int_addr_i;
    logic                       reg_we_o;
    logic [`EXU_REG_ADDR_W-1:0] reg_waddr_o;
    logic [`EXU_XLEN-1:0]       reg_wdata_o;
    logic                       jump_flag_o;
    logic [`EXU_XLEN-1:0]       jump_addr_o;
    logic                       hold_o;

    // current vector, inputs then expected outputs
    logic [31:0] f_op, f_pc, f_rs1, f_rs2, f_imm, f_use_imm, f_rd, f_irq, f_irq_addr;
    logic [31:0] e_we, e_wdata, e_jump, e_jaddr;

    exu_top DUT (.*);

    always #HALF_PERIOD clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else begin
            fail_now($sformatf("[ERROR] time %0t: %s expected 0x%08h, got 0x%08h",
                               $time, name, exp, act));
        end
    endtask

    function automatic logic is_muldiv(input logic [31:0] code);
        exu_op_e op;
        op = exu_op_e'(code[4:0]);
        return op inside {OP_MUL, OP_MULHU, OP_DIVU, OP_REMU};
    endfunction

    task automatic drive_vector(input logic irq);
        valid_i      = 1'b1;
        op_i         = exu_op_e'(f_op[4:0]);
        pc_i         = f_pc;
        rs1_i        = f_rs1;
        rs2_i        = f_rs2;
        imm_i        = f_imm;
        use_imm_i    = f_use_imm[0];
        rd_i         = f_rd[`EXU_REG_ADDR_W-1:0];
        int_assert_i = irq;
        int_addr_i   = f_irq_addr;
    endtask

    // ALU and branch results settle within the issue cycle
    task automatic run_single();
        @(negedge clk);
        drive_vector(f_irq[0]);
        #(HALF_PERIOD - 1);
        check_value("reg_we_o", e_we, 32'(reg_we_o));
        if (e_we[0]) begin
            check_value("reg_waddr_o", f_rd, 32'(reg_waddr_o));
            check_value("reg_wdata_o", e_wdata, reg_wdata_o);
        end
        check_value("jump_flag_o", e_jump, 32'(jump_flag_o));
        if (e_jump[0]) begin
            check_value("jump_addr_o", e_jaddr, jump_addr_o);
        end
        check_value("hold_o", 32'd0, 32'(hold_o));
    endtask

    task automatic run_muldiv();
        int waits;
        @(negedge clk);
        drive_vector(1'b0);
        #(HALF_PERIOD - 1);
        check_value("hold_o", 32'd1, 32'(hold_o));
        check_value("reg_we_o", 32'd0, 32'(reg_we_o));
        @(negedge clk);
        // edges counted from the one that ends the issue cycle
        waits = 0;
        while (!reg_we_o) begin
            assert (waits < TIMEOUT) else fail_now("timeout waiting for the muldiv write-back");
            check_value("hold_o", 32'd1, 32'(hold_o));
            valid_i = 1'b0;
            @(negedge clk);
            waits++;
        end
        check_value("muldiv latency", 32'(`EXU_MULDIV_STEPS + 1), 32'(waits));
        check_value("reg_waddr_o", f_rd, 32'(reg_waddr_o));
        check_value("reg_wdata_o", e_wdata, reg_wdata_o);
        check_value("jump_flag_o", e_jump, 32'(jump_flag_o));
        check_value("hold_o", 32'd0, 32'(hold_o));
    endtask

    // issue a muldiv op, then cancel it with an interrupt
    task automatic run_cancel();
        int waits;
        @(negedge clk);
        drive_vector(1'b0);
        repeat (IRQ_DELAY) begin
            @(negedge clk);
            check_value("hold_o", 32'd1, 32'(hold_o));
            valid_i = 1'b0;
        end
        int_assert_i = 1'b1;
        #(HALF_PERIOD - 1);
        check_value("reg_we_o", e_we, 32'(reg_we_o));
        check_value("jump_flag_o", e_jump, 32'(jump_flag_o));
        check_value("jump_addr_o", e_jaddr, jump_addr_o);
        @(negedge clk);
        int_assert_i = 1'b0;
        waits = 0;
        while (hold_o) begin
            assert (waits < TIMEOUT) else fail_now("hold_o stayed high after the interrupt");
            check_value("reg_we_o", 32'd0, 32'(reg_we_o));
            @(negedge clk);
            waits++;
        end
        // the cancelled op stays silent past the time it would have finished
        repeat (`EXU_MULDIV_STEPS + 1) begin
            check_value("reg_we_o", 32'd0, 32'(reg_we_o));
            check_value("hold_o", 32'd0, 32'(hold_o));
            @(negedge clk);
        end
    endtask

    initial begin
        int    fd;
        int    n;
        int    count;
        string line;

        rst_n_i      = 1'b0;
        valid_i      = 1'b0;
        op_i         = OP_NONE;
        pc_i         = '0;
        rs1_i        = '0;
        rs2_i        = '0;
        imm_i        = '0;
        use_imm_i    = 1'b0;
        rd_i         = '0;
        int_assert_i = 1'b0;
        int_addr_i   = '0;
        count        = 0;

        repeat (8) @(negedge clk);
        rst_n_i = 1'b1;
        #(HALF_PERIOD - 1);
        check_value("reg_we_o", 32'd0, 32'(reg_we_o));
        check_value("jump_flag_o", 32'd0, 32'(jump_flag_o));
        check_value("hold_o", 32'd0, 32'(hold_o));
        check_value("muldiv state", 32'(MD_IDLE), 32'(DUT.u_muldiv.state_q));

        fd = $fopen("verif/exu_testdata.txt", "r");
        assert (fd != 0) else fail_now("cannot open verif/exu_testdata.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // skip blank lines and lines starting with #
            if (n > 1 && line.getc(0) != 8'h23) begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                            f_op, f_pc, f_rs1, f_rs2, f_imm, f_use_imm, f_rd,
                            f_irq, f_irq_addr, e_we, e_wdata, e_jump, e_jaddr);
                assert (n == 13) else fail_now("malformed line in the vector file");
                count++;
                if (is_muldiv(f_op) && f_irq[0]) begin
                    run_cancel();
                end else if (is_muldiv(f_op)) begin
                    run_muldiv();
                end else begin
                    run_single();
                end
            end
        end
        $fclose(fd);
        assert (count > 0) else fail_now("the vector file holds no vectors");

        @(negedge clk);
        valid_i = 1'b0;
        repeat (2) @(negedge clk);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== verif/exu_testdata.txt ====
# op pc rs1 rs2 imm use_imm rd int_assert int_addr | reg_we reg_wdata jump_flag jump_addr
# hex fields, op is the exu_op_e code, a muldiv op with int_assert set gets cancelled
01 00000100 00000005 00000003 00000000 0 01 0 00000000 1 00000008 0 00000000
01 00000100 0000000a 00000000 fffffffe 1 02 0 00000000 1 00000008 0 00000000
02 00000100 00000003 00000005 00000000 0 03 0 00000000 1 fffffffe 0 00000000
03 00000100 00000001 00000000 00000024 1 04 0 00000000 1 00000010 0 00000000
04 00000100 ffffffff 00000001 00000000 0 05 0 00000000 1 00000001 0 00000000
05 00000100 ffffffff 00000001 00000000 0 06 0 00000000 1 00000000 0 00000000
06 00000100 0f0f0f0f 00000000 ffff0000 1 07 0 00000000 1 f0f00f0f 0 00000000
07 00000100 80000000 00000004 00000000 0 08 0 00000000 1 08000000 0 00000000
08 00000100 80000000 00000000 00000004 1 09 0 00000000 1 f8000000 0 00000000
09 00000100 0f0f0000 0000f0f0 00000000 0 0a 0 00000000 1 0f0ff0f0 0 00000000
0a 00000100 12345678 00000000 0000ff00 1 0b 0 00000000 1 00005600 0 00000000
0b 00000100 00000000 00000000 12345000 1 0c 0 00000000 1 12345000 0 00000000
0c 00001000 00000000 00000000 00002000 1 0d 0 00000000 1 00003000 0 00000000
01 00000100 00000001 00000001 00000000 0 00 0 00000000 0 00000000 0 00000000
0f 00000200 00000005 00000005 00000040 0 0e 0 00000000 0 00000000 1 00000240
0f 00000200 00000005 00000006 00000040 0 0e 0 00000000 0 00000000 0 00000000
10 00000200 00000005 00000006 00000040 0 0e 0 00000000 0 00000000 1 00000240
10 00000200 00000005 00000005 00000040 0 0e 0 00000000 0 00000000 0 00000000
11 00000200 ffffffff 00000001 00000040 0 0e 0 00000000 0 00000000 1 00000240
11 00000200 00000001 ffffffff 00000040 0 0e 0 00000000 0 00000000 0 00000000
12 00000200 00000001 ffffffff 00000040 0 0e 0 00000000 0 00000000 1 00000240
12 00000200 ffffffff 00000001 00000040 0 0e 0 00000000 0 00000000 0 00000000
13 00000200 00000001 ffffffff 00000040 0 0e 0 00000000 0 00000000 1 00000240
13 00000200 ffffffff 00000001 00000040 0 0e 0 00000000 0 00000000 0 00000000
14 00000200 ffffffff 00000001 00000040 0 0e 0 00000000 0 00000000 1 00000240
14 00000200 00000001 ffffffff 00000040 0 0e 0 00000000 0 00000000 0 00000000
0d 00000300 00000000 00000000 00000100 0 01 0 00000000 1 00000304 1 00000400
0e 00000300 00001001 00000000 00000004 0 01 0 00000000 1 00000304 1 00001004
15 00000400 ffffffff ffffffff 00000000 0 05 0 00000000 1 00000001 0 00000000
16 00000400 ffffffff ffffffff 00000000 0 05 0 00000000 1 fffffffe 0 00000000
17 00000400 00000064 00000007 00000000 0 05 0 00000000 1 0000000e 0 00000000
18 00000400 00000064 00000007 00000000 0 05 0 00000000 1 00000002 0 00000000
17 00000400 00000064 00000000 00000000 0 05 0 00000000 1 ffffffff 0 00000000
18 00000400 00000064 00000000 00000000 0 05 0 00000000 1 00000064 0 00000000
15 00000400 00000003 00000005 00000000 0 05 1 00000800 0 00000000 1 00000800
01 00000404 00000002 00000003 00000000 0 06 0 00000000 1 00000005 0 00000000

// ==== project.f ====
+incdir+common
common/exu_pkg.sv
common/muldiv_if.sv
design/exu_dispatch.sv
design/exu_alu.sv
design/exu_bru.sv
design/exu_commit.sv
muldiv/exu_muldiv.sv
design/exu_top.sv
verif/exu_assert.sv
verif/tb_exu.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the execute stage testbench with Verilator and runs it
# the run passes only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f project.f --top-module tb_exu -o tb_exu &&
    ./obj_dir/tb_exu | tee sim.log &&
    grep -q "^ALL TESTS PASSED$" sim.log &&
    echo "simulation passed" ||
    { echo "simulation failed, see sim.log"; exit 1; }
